/* mem_pkg.sv */
package mem_pkg;

    // Default word-address width and the matching depth
    localparam int ADDR_W_DEF = 8;
    localparam int DEPTH_DEF  = 2 ** ADDR_W_DEF;

    // Width of one memory word
    localparam int DATA_W = 32;

    // Load/store opcodes from bits 15:9 of the instruction
    // Immediate, SP, literal and multiple forms only use bits 6:2,
    // so they are listed with their two low bits cleared
    typedef enum logic [6:0] {
        STR      = 7'b0101_000,
        STRH     = 7'b0101_001,
        STRB     = 7'b0101_010,
        LDRSB    = 7'b0101_011,
        LDR      = 7'b0101_100,
        LDRH     = 7'b0101_101,
        LDRB     = 7'b0101_110,
        LDRSH    = 7'b0101_111,
        STR_IMM  = 7'b0110_000,
        LDR_IMM  = 7'b0110_100,
        STRB_IMM = 7'b0111_000,
        LDRB_IMM = 7'b0111_100,
        STRH_IMM = 7'b1000_000,
        LDRH_IMM = 7'b1000_100,
        STR_SP   = 7'b1001_000,
        LDR_SP   = 7'b1001_100,
        LDR_LIT  = 7'b0100_100,
        STM      = 7'b1100_000,
        LDM      = 7'b1100_100,
        PUSH     = 7'b1011_010,
        POP      = 7'b1011_110
    } ls_op_e;

    // Access size encoded as the index of the highest lane touched
    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd3
    } acc_size_e;

    // One access towards the lane memory
    typedef struct packed {
        logic                  valid;
        logic                  write;
        acc_size_e             size;
        logic                  sign;
        logic [ADDR_W_DEF-1:0] addr;
        logic [DATA_W-1:0]     wdata;
    } acc_t;

endpackage

/* byte_ram.sv */
module byte_ram #(
    parameter int ADDR_W = mem_pkg::ADDR_W_DEF,
    parameter int DEPTH  = mem_pkg::DEPTH_DEF
) (
    input  logic              clk,
    input  logic              we,
    input  logic [ADDR_W-1:0] addr,
    input  logic [7:0]        wdata,
    output logic [7:0]        rdata
);

    logic [7:0] mem [DEPTH];

    // Storage written on the clock edge
    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[addr] <= wdata;
        end
    end

    // Registered read of the addressed byte every cycle
    always_ff @(posedge clk)
    begin
        rdata <= mem[addr];
    end

endmodule

/* access_decode.sv */
module access_decode #(
    parameter int ADDR_W = mem_pkg::ADDR_W_DEF
) (
    input  logic                       cpu_req,
    input  logic [6:0]                 cpu_opcode,
    input  logic [ADDR_W-1:0]          cpu_addr,
    input  logic [mem_pkg::DATA_W-1:0] cpu_wdata,
    output mem_pkg::acc_t              cpu_acc
);

    import mem_pkg::*;

    ls_op_e    op_full;
    ls_op_e    op_form;
    logic      known;
    logic      write;
    acc_size_e size;
    logic      sign;

    // Full code for register forms and push/pop
    assign op_full = ls_op_e'(cpu_opcode);
    // Low two bits masked for the forms that only use bits 6:2
    assign op_form = ls_op_e'({cpu_opcode[6:2], 2'b00});

    always_comb
    begin
        known = 1'b1;
        write = 1'b0;
        size  = WORD;
        sign  = 1'b0;
        case (op_full)
            STR:
                write = 1'b1;
            STRH:
            begin
                write = 1'b1;
                size  = HALF;
            end
            STRB:
            begin
                write = 1'b1;
                size  = BYTE;
            end
            LDR:
                size = WORD;
            LDRH:
                size = HALF;
            LDRB:
                size = BYTE;
            LDRSB:
            begin
                size = BYTE;
                sign = 1'b1;
            end
            LDRSH:
            begin
                size = HALF;
                sign = 1'b1;
            end
            // Only the single-word step of a push or pop
            PUSH:
                write = 1'b1;
            POP:
                write = 1'b0;
            default:
            begin
                case (op_form)
                    STR_IMM, STR_SP, STM:
                        write = 1'b1;
                    LDR_IMM, LDR_SP, LDR_LIT, LDM:
                        write = 1'b0;
                    STRB_IMM:
                    begin
                        write = 1'b1;
                        size  = BYTE;
                    end
                    LDRB_IMM:
                        size = BYTE;
                    STRH_IMM:
                    begin
                        write = 1'b1;
                        size  = HALF;
                    end
                    LDRH_IMM:
                        size = HALF;
                    default:
                        known = 1'b0;
                endcase
            end
        endcase
    end

    assign cpu_acc.valid = cpu_req & known;
    assign cpu_acc.write = write;
    assign cpu_acc.size  = size;
    assign cpu_acc.sign  = sign;
    assign cpu_acc.addr  = ADDR_W_DEF'(cpu_addr);
    assign cpu_acc.wdata = cpu_wdata;

endmodule

/* mem_arbiter.sv */
module mem_arbiter (
    input  mem_pkg::acc_t cpu_acc,
    input  mem_pkg::acc_t load_acc,
    output mem_pkg::acc_t mem_acc,
    output logic          load_grant
);

    logic cpu_sel;

    // CPU always wins and is never held off
    assign cpu_sel = cpu_acc.valid;

    // Loader goes through on any cycle without a CPU access
    assign load_grant = load_acc.valid & ~cpu_sel;

    always_comb
    begin
        if (cpu_sel)
        begin
            mem_acc = cpu_acc;
        end
        else if (load_acc.valid)
        begin
            mem_acc = load_acc;
        end
        else
        begin
            // Keep the CPU fields when idle so the bus does not toggle
            mem_acc       = cpu_acc;
            mem_acc.valid = 1'b0;
        end
    end

endmodule

/* lane_mem.sv */
module lane_mem #(
    parameter int ADDR_W = mem_pkg::ADDR_W_DEF,
    parameter int DEPTH  = mem_pkg::DEPTH_DEF
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  mem_pkg::acc_t              mem_acc,
    output logic [mem_pkg::DATA_W-1:0] rdata,
    output logic                       rvalid
);

    import mem_pkg::*;

    acc_t              acc_q;
    logic              acc_vld_q;
    logic [3:0]        lane_we;
    logic [ADDR_W-1:0] ram_addr;
    logic [3:0][7:0]   lane_rdata;
    acc_size_e         size_q;
    logic              sign_q;
    logic              rvalid_q;

    // Access stage
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            acc_vld_q <= 1'b0;
        end
        else
        begin
            acc_vld_q <= mem_acc.valid;
        end
    end

    always_ff @(posedge clk)
    begin
        acc_q <= mem_acc;
    end

    assign ram_addr = ADDR_W'(acc_q.addr);

    // Byte writes lane 0, halfword lanes 0-1, word all four
    always_comb
    begin
        lane_we = 4'b0000;
        if (acc_vld_q && acc_q.write)
        begin
            case (acc_q.size)
                BYTE:    lane_we = 4'b0001;
                HALF:    lane_we = 4'b0011;
                WORD:    lane_we = 4'b1111;
                default: lane_we = 4'b0000;
            endcase
        end
    end

    for (genvar i = 0; i < 4; i++)
    begin : g_lane
        byte_ram #(
            .ADDR_W (ADDR_W),
            .DEPTH  (DEPTH)
        ) u_ram (
            .clk   (clk),
            .we    (lane_we[i]),
            .addr  (ram_addr),
            .wdata (acc_q.wdata[8*i +: 8]),
            .rdata (lane_rdata[i])
        );
    end

    // Format info follows the read by one cycle
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rvalid_q <= 1'b0;
        end
        else
        begin
            rvalid_q <= acc_vld_q & ~acc_q.write;
        end
    end

    always_ff @(posedge clk)
    begin
        size_q <= acc_q.size;
        sign_q <= acc_q.sign;
    end

    // Zero or sign fill above the lanes read
    always_comb
    begin
        case (size_q)
            BYTE:    rdata = {{24{sign_q & lane_rdata[0][7]}}, lane_rdata[0]};
            HALF:    rdata = {{16{sign_q & lane_rdata[1][7]}}, lane_rdata[1], lane_rdata[0]};
            WORD:    rdata = lane_rdata;
            default: rdata = '0;
        endcase
    end

    assign rvalid = rvalid_q;

endmodule

/* mem_loader.sv */
module mem_loader #(
    parameter int ADDR_W = mem_pkg::ADDR_W_DEF
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       load_valid,
    input  logic [ADDR_W-1:0]          load_addr,
    input  logic [mem_pkg::DATA_W-1:0] load_data,
    input  logic                       load_grant,
    output mem_pkg::acc_t              load_acc,
    output logic                       load_busy
);

    import mem_pkg::*;

    logic              busy_q;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] data_q;

    // Busy from capture until the write is granted
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy_q <= 1'b0;
        end
        else if (busy_q)
        begin
            busy_q <= ~load_grant;
        end
        else
        begin
            busy_q <= load_valid;
        end
    end

    // New word only taken while idle
    always_ff @(posedge clk)
    begin
        if (load_valid && !busy_q)
        begin
            addr_q <= load_addr;
            data_q <= load_data;
        end
    end

    assign load_acc.valid = busy_q;
    assign load_acc.write = 1'b1;
    assign load_acc.size  = WORD;
    assign load_acc.sign  = 1'b0;
    assign load_acc.addr  = ADDR_W_DEF'(addr_q);
    assign load_acc.wdata = data_q;

    assign load_busy = busy_q;

endmodule

/* mem_subsys_top.sv */
module mem_subsys_top #(
    parameter int ADDR_W = mem_pkg::ADDR_W_DEF
) (
    input  logic                       clk,
    input  logic                       rst_n,
    // CPU data port
    input  logic                       cpu_req,
    input  logic [6:0]                 cpu_opcode,
    input  logic [ADDR_W-1:0]          cpu_addr,
    input  logic [mem_pkg::DATA_W-1:0] cpu_wdata,
    output logic [mem_pkg::DATA_W-1:0] cpu_rdata,
    output logic                       cpu_rvalid,
    // Host loader port
    input  logic                       load_valid,
    input  logic [ADDR_W-1:0]          load_addr,
    input  logic [mem_pkg::DATA_W-1:0] load_data,
    output logic                       load_busy
);

    import mem_pkg::*;

    localparam int DEPTH = 2 ** ADDR_W;

    acc_t cpu_acc;
    acc_t load_acc;
    acc_t mem_acc;
    logic load_grant;

    access_decode #(
        .ADDR_W (ADDR_W)
    ) u_decode (
        .cpu_req    (cpu_req),
        .cpu_opcode (cpu_opcode),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_acc    (cpu_acc)
    );

    mem_loader #(
        .ADDR_W (ADDR_W)
    ) u_loader (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .load_grant (load_grant),
        .load_acc   (load_acc),
        .load_busy  (load_busy)
    );

    mem_arbiter u_arbiter (
        .cpu_acc    (cpu_acc),
        .load_acc   (load_acc),
        .mem_acc    (mem_acc),
        .load_grant (load_grant)
    );

    lane_mem #(
        .ADDR_W (ADDR_W),
        .DEPTH  (DEPTH)
    ) u_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .mem_acc (mem_acc),
        .rdata   (cpu_rdata),
        .rvalid  (cpu_rvalid)
    );

endmodule

/* tb_mem_subsys.sv */
module tb_mem_subsys;

    import mem_pkg::*;

    // Access class of an opcode from the load/store table
    typedef struct packed {
        logic       known;
        logic       write;
        logic       sign;
        logic [2:0] nbytes;
    } op_info_t;

    localparam int RAND_CYCLES = 400;
    // Reset, directed tests and the preload come to about 120 cycles
    localparam int CYCLE_LIMIT = 2 * (120 + RAND_CYCLES);

    logic        clk = 1'b0;
    logic        rst_n;
    logic        cpu_req;
    logic [6:0]  cpu_opcode;
    logic [7:0]  cpu_addr;
    logic [31:0] cpu_wdata;
    logic [31:0] cpu_rdata;
    logic        cpu_rvalid;
    logic        load_valid;
    logic [7:0]  load_addr;
    logic [31:0] load_data;
    logic        load_busy;

    // Reference model
    logic [31:0] ref_mem [256];
    op_info_t    cur_op;
    logic        cpu_hit;
    logic [31:0] mask;
    logic [31:0] word;
    logic        model_live = 1'b0;
    logic        pend = 1'b0;
    logic [7:0]  pend_addr;
    logic [31:0] pend_data;
    logic        exp_v1 = 1'b0;
    logic        exp_v2 = 1'b0;
    logic [31:0] exp_d1;
    logic [31:0] exp_d2;

    integer      seed = 32'h29e8_8ffe;
    logic [31:0] r;
    int          errs = 0;
    int          checks = 0;
    int          errs_base = 0;
    int          checks_base = 0;
    int          cycles = 0;

    mem_subsys_top #(.ADDR_W(8)) DUT (.*);

    always #5 clk = ~clk;

    function automatic op_info_t classify(input logic [6:0] op);
        op_info_t info;
        casez (op)
            // Word stores in register, immediate, SP, multiple and push forms
            7'b0101_000, 7'b0110_0??, 7'b1001_0??, 7'b1100_0??, 7'b1011_010:
                info = {1'b1, 1'b1, 1'b0, 3'd4};
            // Word loads in register, immediate, SP, literal, multiple and pop forms
            7'b0101_100, 7'b0110_1??, 7'b1001_1??, 7'b0100_1??, 7'b1100_1??, 7'b1011_110:
                info = {1'b1, 1'b0, 1'b0, 3'd4};
            7'b0101_010, 7'b0111_0??: info = {1'b1, 1'b1, 1'b0, 3'd1};
            7'b0101_110, 7'b0111_1??: info = {1'b1, 1'b0, 1'b0, 3'd1};
            7'b0101_001, 7'b1000_0??: info = {1'b1, 1'b1, 1'b0, 3'd2};
            7'b0101_101, 7'b1000_1??: info = {1'b1, 1'b0, 1'b0, 3'd2};
            7'b0101_011:              info = {1'b1, 1'b0, 1'b1, 3'd1};
            7'b0101_111:              info = {1'b1, 1'b0, 1'b1, 3'd2};
            default:                  info = {1'b0, 1'b0, 1'b0, 3'd4};
        endcase
        return info;
    endfunction

    // Bits covered by the low lanes of an access
    function automatic logic [31:0] lane_mask(input int nbytes);
        return (nbytes == 4) ? 32'hffff_ffff : (32'h1 << (8 * nbytes)) - 1;
    endfunction

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("FAIL %s: got %h expected %h at %0t", name, got, exp, $time);
        errs++;
    endtask

    task automatic cpu_access(input logic [6:0] op, input logic [7:0] addr,
                              input logic [31:0] data);
        cpu_req    = 1'b1;
        cpu_opcode = op;
        cpu_addr   = addr;
        cpu_wdata  = data;
        @(negedge clk);
        cpu_req = 1'b0;
    endtask

    task automatic host_write(input logic [7:0] addr, input logic [31:0] data);
        load_valid = 1'b1;
        load_addr  = addr;
        load_data  = data;
        @(negedge clk);
        load_valid = 1'b0;
        while (load_busy)
            @(negedge clk);
    endtask

    task automatic end_test(input string name);
        repeat (2)
            @(negedge clk);
        @(posedge clk);
        $display("%s: %0d checks, %0d errors", name, checks - checks_base,
                 errs - errs_base);
        checks_base = checks;
        errs_base   = errs;
        @(negedge clk);
    endtask

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > CYCLE_LIMIT)
        begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // Mirrors what the memory samples on each rising edge
    always @(posedge clk)
    begin
        model_live = rst_n;
        cur_op     = classify(cpu_opcode);
        cpu_hit    = rst_n && cpu_req && cur_op.known;
        mask       = lane_mask(cur_op.nbytes);
        word       = ref_mem[cpu_addr];
        exp_v2     = exp_v1;
        exp_d2     = exp_d1;
        exp_v1     = cpu_hit && !cur_op.write;
        if (exp_v1)
            exp_d1 = (cur_op.sign && word[8 * cur_op.nbytes - 1]) ? word | ~mask : word & mask;
        else if (cpu_hit)
            ref_mem[cpu_addr] = (word & ~mask) | (cpu_wdata & mask);
        // Pending host word goes in on a cycle without a CPU access
        if (!rst_n)
            pend = 1'b0;
        else if (pend && !cpu_hit)
        begin
            ref_mem[pend_addr] = pend_data;
            pend = 1'b0;
        end
        else if (!pend && load_valid)
        begin
            pend      = 1'b1;
            pend_addr = load_addr;
            pend_data = load_data;
        end
    end

    always @(negedge clk)
    begin
        if (model_live)
        begin
            checks += 3;
            assert (cpu_rvalid === exp_v2)
            else
                report_value("cpu_rvalid", cpu_rvalid, exp_v2);
            assert (!exp_v2 || cpu_rdata === exp_d2)
            else
                report_value("cpu_rdata", cpu_rdata, exp_d2);
            assert (load_busy === pend)
            else
                report_value("load_busy", load_busy, pend);
        end
    end

    initial
    begin
        rst_n      = 1'b0;
        cpu_req    = 1'b0;
        cpu_opcode = '0;
        cpu_addr   = '0;
        cpu_wdata  = '0;
        load_valid = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        repeat (4)
            @(negedge clk);
        rst_n = 1'b1;

        cpu_access(STR_IMM | 7'd2, 8'h10, 32'hdead_beef);
        cpu_access(STR_SP | 7'd3, 8'h11, 32'h0123_4567);
        cpu_access(PUSH, 8'h12, 32'h89ab_cdef);
        cpu_access(LDR_IMM | 7'd1, 8'h10, '0);
        cpu_access(LDR_SP, 8'h11, '0);
        cpu_access(POP, 8'h12, '0);
        end_test("reset and word access");

        cpu_access(STR, 8'h20, 32'h1122_3344);
        cpu_access(STR, 8'h21, 32'h5566_7788);
        cpu_access(STRB, 8'h20, 32'hffff_ffaa);
        cpu_access(STRH_IMM | 7'd1, 8'h21, 32'hffff_bbcc);
        cpu_access(LDR, 8'h20, '0);
        cpu_access(LDR, 8'h21, '0);
        cpu_access(LDRB_IMM | 7'd3, 8'h21, '0);
        end_test("byte and half store lanes");

        // Byte and half top bits in all four combinations
        cpu_access(STR, 8'h30, 32'h1234_80f0);
        cpu_access(STR, 8'h31, 32'h5678_7f7f);
        cpu_access(STR, 8'h32, 32'h9abc_7f80);
        cpu_access(STR, 8'h33, 32'hdef0_807f);
        for (int a = 8'h30; a < 8'h34; a++)
        begin
            cpu_access(LDRB, 8'(a), '0);
            cpu_access(LDRSB, 8'(a), '0);
            cpu_access(LDRH, 8'(a), '0);
            cpu_access(LDRSH, 8'(a), '0);
        end
        end_test("load extension");

        cpu_access(STR, 8'h38, 32'hcafe_f00d);
        cpu_access(7'b0000_000, 8'h38, 32'h1111_1111);
        cpu_access(7'b1111_111, 8'h38, 32'h2222_2222);
        cpu_access(7'b1011_011, 8'h38, 32'h3333_3333);
        cpu_access(LDR, 8'h38, '0);
        end_test("unknown opcode");

        host_write(8'h50, 32'h5a5a_0050);
        host_write(8'h51, 32'h5a5a_0051);
        load_valid = 1'b1;
        load_addr  = 8'h52;
        load_data  = 32'h5a5a_0052;
        cpu_access(LDR, 8'h50, '0);
        load_valid = 1'b0;
        repeat (6)
            cpu_access(LDR_SP, 8'h51, '0);
        assert (load_busy === 1'b1)
        else
            report_value("load_busy", load_busy, 1);
        while (load_busy)
            @(negedge clk);
        cpu_access(LDR, 8'h52, '0);
        end_test("loader under CPU traffic");

        // Preload the random window so every read is defined
        for (int i = 0; i < 16; i++)
            host_write(8'(8'h40 + i), $random(seed));
        for (int i = 0; i < RAND_CYCLES; i++)
        begin
            r          = $random(seed);
            cpu_req    = r[0] | r[1];
            cpu_opcode = r[9] ? {4'b0101, r[4:2]} : r[8:2];
            cpu_addr   = {4'h4, r[19:16]};
            cpu_wdata  = $random(seed);
            load_valid = !load_busy && (r[22:20] == 3'd0);
            load_addr  = {4'h4, r[27:24]};
            load_data  = $random(seed);
            @(negedge clk);
        end
        cpu_req    = 1'b0;
        load_valid = 1'b0;
        while (load_busy)
            @(negedge clk);
        end_test("random mix");

        $display("Total: %0d checks, %0d errors", checks, errs);
        if (errs == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* project.f */
mem_pkg.sv
byte_ram.sv
access_decode.sv
mem_arbiter.sv
lane_mem.sv
mem_loader.sv
mem_subsys_top.sv
tb_mem_subsys.sv

/* Bender.yml */
package:
  name: mem_subsys

sources:
  - mem_pkg.sv
  - byte_ram.sv
  - access_decode.sv
  - mem_arbiter.sv
  - lane_mem.sv
  - mem_loader.sv
  - mem_subsys_top.sv
  - target: test
    files:
      - tb_mem_subsys.sv
